// File: sim.f
+incdir+verif
design/grid_geom_pkg.sv
design/game_pkg.sv
design/cell_port_if.sv
design/pos_to_cell.sv
design/cell_store.sv
design/fleet_placer.sv
design/shot_resolver.sv
design/grid_arbiter.sv
design/grid_engine_top.sv
verif/grid_engine_tb.sv

// File: Makefile
VERILATOR  = verilator
TOP        = grid_engine_tb
FILELIST   = sim.f
OBJ_DIR    = obj_dir
VFLAGS     = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
PASS_MSG   = All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: verif/grid_model.svh
`ifndef GRID_MODEL_SVH
`define GRID_MODEL_SVH

////////////////////////////////////////
// reference game state
////////////////////////////////////////
// one word per cell, same field layout as the store
logic [game_pkg::CELL_W-1:0] model_grid [GRID_ROWS][GRID_COLS];
// next ship to place and current direction
int model_ptr;
bit model_vert;
// ship cells on the board and ship cells hit so far
int model_cells;
int model_hits;
logic [game_pkg::PHASE_W-1:0] model_phase;
int check_count;
int error_count;

// compare one value, mismatch shown at once
task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
	check_count++;
	if (got !== exp)
	begin
		error_count++;
		$display("** Error: %s = 0x%0h, expected 0x%0h (time %0t)", name, got, exp, $time);
	end
endtask

// state right after reset
function automatic void clear_model();
	for (int r = 0; r < GRID_ROWS; r++)
		for (int c = 0; c < GRID_COLS; c++)
			model_grid[r][c] = '0;
	model_ptr   = 0;
	model_vert  = 1'b0;
	model_cells = 0;
	model_hits  = 0;
	model_phase = game_pkg::PH_PLACE;
endfunction

// footprint cell k of a ship anchored at (c, r)
function automatic int fp_col(input int c, input int k);
	return model_vert ? c : c + k;
endfunction

function automatic int fp_row(input int r, input int k);
	return model_vert ? r + k : r;
endfunction

// whole ship stays inside the grid
function automatic bit ship_fits(input int c, input int r, input int len);
	if (model_vert)
		return r + len <= GRID_ROWS;
	return c + len <= GRID_COLS;
endfunction

// accepted when it fits and every footprint cell is still water
function automatic bit predict_place(input int c, input int r, input int len);
	bit clear;
	clear = ship_fits(c, r, len);
	for (int k = 0; k < len && clear; k++)
		if (model_grid[fp_row(r, k)][fp_col(c, k)][game_pkg::LAYOUT_LSB +: game_pkg::FIELD_W]
			!= game_pkg::LAY_WATER)
			clear = 1'b0;
	return clear;
endfunction

function automatic void commit_place(input int c, input int r, input int len);
	for (int k = 0; k < len; k++)
		model_grid[fp_row(r, k)][fp_col(c, k)][game_pkg::LAYOUT_LSB +: game_pkg::FIELD_W] =
			game_pkg::LAY_SHIP;
	model_cells += len;
	model_ptr++;
	// last ship opens the firing phase
	if (model_ptr == NUM_SHIPS)
		model_phase = game_pkg::PH_FIRE;
endfunction

// repeat beats hit, hit needs a ship under the shot
function automatic logic [game_pkg::RES_W-1:0] predict_shot(input int c, input int r);
	if (model_grid[r][c][game_pkg::SHOT_LSB +: game_pkg::FIELD_W] != game_pkg::SHOT_NONE)
		return game_pkg::RES_REPEAT;
	if (model_grid[r][c][game_pkg::LAYOUT_LSB +: game_pkg::FIELD_W] == game_pkg::LAY_SHIP)
		return game_pkg::RES_HIT;
	return game_pkg::RES_MISS;
endfunction

function automatic void commit_shot(input int c, input int r);
	if (model_grid[r][c][game_pkg::SHOT_LSB +: game_pkg::FIELD_W] != game_pkg::SHOT_NONE)
		return;
	model_grid[r][c][game_pkg::SHOT_LSB +: game_pkg::FIELD_W] = game_pkg::SHOT_FIRED;
	if (model_grid[r][c][game_pkg::LAYOUT_LSB +: game_pkg::FIELD_W] == game_pkg::LAY_SHIP)
		model_hits++;
	// whole fleet sunk
	if (model_cells != 0 && model_hits == model_cells)
		model_phase = game_pkg::PH_OVER;
endfunction

`endif

// File: verif/grid_engine_tb.sv
module grid_engine_tb;

	localparam int PERIOD    = 20;
	localparam int COORD_W   = grid_geom_pkg::COORD_W;
	localparam int LEN_W     = grid_geom_pkg::SHIP_LEN_W;
	localparam int GRID_X0   = grid_geom_pkg::DEF_GRID_X0;
	localparam int GRID_Y0   = grid_geom_pkg::DEF_GRID_Y0;
	localparam int CELL_W_PX = grid_geom_pkg::DEF_CELL_W;
	localparam int CELL_H_PX = grid_geom_pkg::DEF_CELL_H;
	localparam int GRID_COLS = grid_geom_pkg::DEF_GRID_COLS;
	localparam int GRID_ROWS = grid_geom_pkg::DEF_GRID_ROWS;
	localparam int NUM_SHIPS = grid_geom_pkg::DEF_NUM_SHIPS;
	localparam int MAX_LEN   = 5;
	localparam int MAX_ATTEMPTS = 200;
	localparam int NUM_SHOTS = 40;
	// longest wait for a handshake
	localparam int DONE_LIMIT = 64;

	////////////////////////////////////////
	// run length for the watchdog
	////////////////////////////////////////
	localparam int SCAN_CYC  = 4;
	localparam int RESET_CYC = 10 + 2 * GRID_ROWS + 8 * SCAN_CYC;
	localparam int PLACE_CYC = 10 + 3 * MAX_LEN + MAX_LEN * SCAN_CYC;
	localparam int SHOT_CYC  = 8 + SCAN_CYC;
	localparam int FIRE_CYC  = (NUM_SHOTS + GRID_COLS * GRID_ROWS) * SHOT_CYC + 8 * SCAN_CYC;
	// sum of the tests with a margin of two
	localparam int WATCH_CYC = 2 * (RESET_CYC + MAX_ATTEMPTS * PLACE_CYC + 20 + FIRE_CYC);

	logic clk_in = 1'b0;
	logic rst_n;
	logic [COORD_W-1:0] mouse_x;
	logic [COORD_W-1:0] mouse_y;
	logic [COORD_W-1:0] scan_x;
	logic [COORD_W-1:0] scan_y;
	logic place_req;
	logic rotate_req;
	logic fire_req;
	logic [NUM_SHIPS*LEN_W-1:0] ship_lens;
	logic [game_pkg::PHASE_W-1:0] phase;
	logic busy;
	logic place_done;
	logic place_ok;
	logic shot_done;
	logic [game_pkg::RES_W-1:0] shot_result;
	logic [game_pkg::CELL_W-1:0] scan_cell;
	logic scan_in_grid;

	int seed = 32'h2d74_4e63;
	// fleet, first ship first
	int ship_len_tab [NUM_SHIPS] = '{5, 4, 3, 3, 2};
	int attempts;

	`include "grid_model.svh"

	grid_engine_top #(
		.GRID_X0(GRID_X0), .GRID_Y0(GRID_Y0), .CELL_W_PX(CELL_W_PX), .CELL_H_PX(CELL_H_PX),
		.GRID_COLS(GRID_COLS), .GRID_ROWS(GRID_ROWS), .NUM_SHIPS(NUM_SHIPS)
	) grid_engine_inst (
		.clk_in(clk_in), .rst_n(rst_n), .mouse_x(mouse_x), .mouse_y(mouse_y),
		.scan_x(scan_x), .scan_y(scan_y), .place_req(place_req), .rotate_req(rotate_req),
		.fire_req(fire_req), .ship_lens(ship_lens), .phase(phase), .busy(busy),
		.place_done(place_done), .place_ok(place_ok), .shot_done(shot_done),
		.shot_result(shot_result), .scan_cell(scan_cell), .scan_in_grid(scan_in_grid)
	);

	always #(PERIOD / 2) clk_in = ~clk_in;

	function automatic int rand_below(input int n);
		return int'({$random(seed)} % n);
	endfunction

	// random pixel inside cell c or row r
	function automatic logic [COORD_W-1:0] pixel_x(input int c);
		return COORD_W'(GRID_X0 + c * CELL_W_PX + rand_below(CELL_W_PX));
	endfunction

	function automatic logic [COORD_W-1:0] pixel_y(input int r);
		return COORD_W'(GRID_Y0 + r * CELL_H_PX + rand_below(CELL_H_PX));
	endfunction

	task automatic report_failure(input string msg);
		error_count++;
		$display("Failure: %s (time %0t)", msg, $time);
	endtask

	task automatic close_test(input string name, input int mark);
		$display("test %-10s finished, %0d errors", name, error_count - mark);
	endtask

	// cursor moves, then is held two cycles
	task automatic set_cursor(input int c, input int r);
		@(posedge clk_in);
		mouse_x <= pixel_x(c);
		mouse_y <= pixel_y(r);
		repeat (2) @(posedge clk_in);
	endtask

	task automatic wait_idle();
		int waited;
		waited = 0;
		@(negedge clk_in);
		while (busy !== 1'b0 && waited < DONE_LIMIT)
		begin
			@(negedge clk_in);
			waited++;
		end
		if (busy !== 1'b0)
			report_failure("busy stayed high after reset");
	endtask

	// scan word shows up two cycles after the point
	task automatic scan_check(input int c, input int r);
		@(posedge clk_in);
		scan_x <= pixel_x(c);
		scan_y <= pixel_y(r);
		repeat (2) @(posedge clk_in);
		@(negedge clk_in);
		check_value("scan_in_grid", scan_in_grid, 1'b1);
		check_value("scan_cell", scan_cell, model_grid[r][c]);
	endtask

	// left of the grid or below it
	task automatic scan_outside();
		int x;
		int y;
		if (rand_below(2) == 0)
		begin
			x = rand_below(GRID_X0);
			y = rand_below(1 << COORD_W);
		end
		else
		begin
			x = rand_below(1 << COORD_W);
			y = GRID_Y0 + GRID_ROWS * CELL_H_PX
				+ rand_below((1 << COORD_W) - GRID_Y0 - GRID_ROWS * CELL_H_PX);
		end
		@(posedge clk_in);
		scan_x <= COORD_W'(x);
		scan_y <= COORD_W'(y);
		repeat (2) @(posedge clk_in);
		@(negedge clk_in);
		check_value("scan_in_grid", scan_in_grid, 1'b0);
		check_value("scan_cell", scan_cell, '0);
	endtask

	////////////////////////////////////////
	// placement attempt
	////////////////////////////////////////
	task automatic place_attempt(input bit noise);
		int c;
		int r;
		int len;
		int k;
		int waited;
		bit fits;
		bit exp_ok;
		attempts++;
		c = rand_below(GRID_COLS);
		r = rand_below(GRID_ROWS);
		len = ship_len_tab[model_ptr];
		// turn the ship at random while idle
		if (rand_below(2) == 1)
		begin
			@(posedge clk_in);
			rotate_req <= 1'b1;
			@(posedge clk_in);
			rotate_req <= 1'b0;
			model_vert = !model_vert;
		end
		fits = ship_fits(c, r, len);
		exp_ok = predict_place(c, r, len);
		set_cursor(c, r);
		place_req <= 1'b1;
		@(posedge clk_in);
		place_req <= 1'b0;
		// a fitting ship keeps the placer busy for at least three cycles
		if (noise && fits)
		begin
			@(posedge clk_in);
			place_req  <= 1'b1;
			rotate_req <= 1'b1;
			@(posedge clk_in);
			place_req  <= 1'b0;
			rotate_req <= 1'b0;
		end
		waited = 0;
		@(negedge clk_in);
		while (place_done !== 1'b1 && waited < DONE_LIMIT)
		begin
			@(negedge clk_in);
			waited++;
		end
		if (place_done !== 1'b1)
		begin
			report_failure("place_done never came after place_req");
			return;
		end
		check_value("place_ok", place_ok, exp_ok);
		if (exp_ok)
			commit_place(c, r, len);
		// footprint readback, cells past the edge skipped
		for (k = 0; k < len; k++)
			if (fp_col(c, k) < GRID_COLS && fp_row(r, k) < GRID_ROWS)
				scan_check(fp_col(c, k), fp_row(r, k));
	endtask

	// fire strobe in the placement phase must do nothing
	task automatic fire_in_place();
		int c;
		int r;
		c = rand_below(GRID_COLS);
		r = rand_below(GRID_ROWS);
		set_cursor(c, r);
		fire_req <= 1'b1;
		@(posedge clk_in);
		fire_req <= 1'b0;
		repeat (5)
		begin
			@(negedge clk_in);
			check_value("shot_done", shot_done, 1'b0);
			check_value("busy", busy, 1'b0);
		end
		check_value("phase", phase, game_pkg::PH_PLACE);
		scan_check(c, r);
	endtask

	////////////////////////////////////////
	// one shot, result exactly 3 cycles on
	////////////////////////////////////////
	task automatic fire_at(input int c, input int r);
		logic [game_pkg::RES_W-1:0] exp_res;
		int k;
		set_cursor(c, r);
		exp_res = predict_shot(c, r);
		fire_req <= 1'b1;
		for (k = 0; k < 3; k++)
		begin
			@(negedge clk_in);
			check_value("shot_done", shot_done, 1'b0);
			@(posedge clk_in);
			fire_req <= 1'b0;
		end
		@(negedge clk_in);
		check_value("shot_done", shot_done, 1'b1);
		check_value("shot_result", shot_result, exp_res);
		commit_shot(c, r);
		// shot field now set in the store
		scan_check(c, r);
	endtask

	initial
	begin
		int mark;
		int c;
		int r;
		int shot;
		rst_n      = 1'b0;
		mouse_x    = '0;
		mouse_y    = '0;
		scan_x     = '0;
		scan_y     = '0;
		place_req  = 1'b0;
		rotate_req = 1'b0;
		fire_req   = 1'b0;
		for (int i = 0; i < NUM_SHIPS; i++)
			ship_lens[i*LEN_W +: LEN_W] = LEN_W'(ship_len_tab[i]);
		check_count = 0;
		error_count = 0;
		attempts = 0;
		c = 0;
		r = 0;
		clear_model();
		repeat (10) @(posedge clk_in);
		rst_n <= 1'b1;
		wait_idle();

		// test 1, state after reset and the cleared grid
		mark = error_count;
		@(negedge clk_in);
		check_value("phase", phase, game_pkg::PH_PLACE);
		check_value("place_done", place_done, 1'b0);
		check_value("shot_done", shot_done, 1'b0);
		repeat (8) scan_check(rand_below(GRID_COLS), rand_below(GRID_ROWS));
		close_test("reset", mark);

		// test 2, first three ships
		mark = error_count;
		while (model_ptr < 3 && attempts < MAX_ATTEMPTS)
			place_attempt(1'b0);
		close_test("placement", mark);

		// test 3, strobes while busy or out of phase
		mark = error_count;
		fire_in_place();
		while (model_ptr < NUM_SHIPS && attempts < MAX_ATTEMPTS)
			place_attempt(1'b1);
		if (model_ptr < NUM_SHIPS)
			report_failure("fleet not complete within the attempt limit");
		close_test("busy", mark);

		// test 4, firing phase after the last ship
		mark = error_count;
		@(negedge clk_in);
		check_value("phase", phase, model_phase);
		close_test("phase", mark);

		// test 5, random shots
		mark = error_count;
		for (shot = 0; shot < NUM_SHOTS && model_hits < model_cells; shot++)
		begin
			// every fifth shot goes back to the last target
			if (shot % 5 != 4)
			begin
				c = rand_below(GRID_COLS);
				r = rand_below(GRID_ROWS);
			end
			fire_at(c, r);
		end
		close_test("shots", mark);

		// test 6, sink the rest, then game over
		mark = error_count;
		for (r = 0; r < GRID_ROWS; r++)
			for (c = 0; c < GRID_COLS; c++)
				if (model_grid[r][c][game_pkg::LAYOUT_LSB +: game_pkg::FIELD_W]
					== game_pkg::LAY_SHIP && predict_shot(c, r) != game_pkg::RES_REPEAT)
					fire_at(c, r);
		@(posedge clk_in);
		@(negedge clk_in);
		check_value("phase", phase, model_phase);
		repeat (6) scan_outside();
		close_test("game over", mark);

		$display("%0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// hard stop if a handshake hangs
	initial
	begin
		#(WATCH_CYC * PERIOD);
		$display("timeout: the run went past %0d cycles without finishing", WATCH_CYC);
		$display("Checks failed");
		$finish;
	end

endmodule

// File: design/grid_engine_top.sv
module grid_engine_top #(
	parameter int GRID_X0   = grid_geom_pkg::DEF_GRID_X0,
	parameter int GRID_Y0   = grid_geom_pkg::DEF_GRID_Y0,
	parameter int CELL_W_PX = grid_geom_pkg::DEF_CELL_W,
	parameter int CELL_H_PX = grid_geom_pkg::DEF_CELL_H,
	parameter int GRID_COLS = grid_geom_pkg::DEF_GRID_COLS,
	parameter int GRID_ROWS = grid_geom_pkg::DEF_GRID_ROWS,
	parameter int NUM_SHIPS = grid_geom_pkg::DEF_NUM_SHIPS
) (
	input  logic clk_in,
	input  logic rst_n,
	input  logic [grid_geom_pkg::COORD_W-1:0] mouse_x,
	input  logic [grid_geom_pkg::COORD_W-1:0] mouse_y,
	input  logic [grid_geom_pkg::COORD_W-1:0] scan_x,
	input  logic [grid_geom_pkg::COORD_W-1:0] scan_y,
	input  logic place_req,
	input  logic rotate_req,
	input  logic fire_req,
	input  logic [NUM_SHIPS*grid_geom_pkg::SHIP_LEN_W-1:0] ship_lens,
	output logic [game_pkg::PHASE_W-1:0] phase,
	output logic busy,
	output logic place_done,
	output logic place_ok,
	output logic shot_done,
	output logic [game_pkg::RES_W-1:0] shot_result,
	output logic [game_pkg::CELL_W-1:0] scan_cell,
	output logic scan_in_grid
);

	// cursor and scan cells
	logic [grid_geom_pkg::CELL_IDX_W-1:0] cur_col;
	logic [grid_geom_pkg::CELL_IDX_W-1:0] cur_row;
	logic [grid_geom_pkg::CELL_IDX_W-1:0] sc_col;
	logic [grid_geom_pkg::CELL_IDX_W-1:0] sc_row;
	logic sc_in_grid;
	// sequencer handshakes and counts
	logic clearing;
	logic place_start;
	logic fire_start;
	logic vertical;
	logic fleet_done;
	logic placer_active;
	logic resolver_active;
	logic [7:0] cells_placed;
	logic [7:0] hits;

	cell_port_if place_port ();
	cell_port_if shot_port ();
	cell_port_if store_port ();

	////////////////////////////////////////
	// pixel to cell conversion
	////////////////////////////////////////
	pos_to_cell #(
		.GRID_X0(GRID_X0), .GRID_Y0(GRID_Y0), .CELL_W_PX(CELL_W_PX), .CELL_H_PX(CELL_H_PX),
		.GRID_COLS(GRID_COLS), .GRID_ROWS(GRID_ROWS)
	) cursor_cell_inst (
		.clk_in(clk_in), .rst_n(rst_n), .pos_x(mouse_x), .pos_y(mouse_y),
		.cell_col(cur_col), .cell_row(cur_row), .in_grid()
	);

	pos_to_cell #(
		.GRID_X0(GRID_X0), .GRID_Y0(GRID_Y0), .CELL_W_PX(CELL_W_PX), .CELL_H_PX(CELL_H_PX),
		.GRID_COLS(GRID_COLS), .GRID_ROWS(GRID_ROWS)
	) scan_cell_inst (
		.clk_in(clk_in), .rst_n(rst_n), .pos_x(scan_x), .pos_y(scan_y),
		.cell_col(sc_col), .cell_row(sc_row), .in_grid(sc_in_grid)
	);

	////////////////////////////////////////
	// grid memory
	////////////////////////////////////////
	cell_store #(.GRID_COLS(GRID_COLS), .GRID_ROWS(GRID_ROWS)) store_inst (
		.clk_in(clk_in), .rst_n(rst_n), .port(store_port),
		.scan_col(sc_col), .scan_row(sc_row), .scan_in_grid(sc_in_grid),
		.scan_cell(scan_cell), .scan_valid(scan_in_grid), .clearing(clearing)
	);

	////////////////////////////////////////
	// sequencers and arbiter
	////////////////////////////////////////
	fleet_placer #(
		.GRID_COLS(GRID_COLS), .GRID_ROWS(GRID_ROWS), .NUM_SHIPS(NUM_SHIPS)
	) placer_inst (
		.clk_in(clk_in), .rst_n(rst_n), .start(place_start), .col(cur_col), .row(cur_row),
		.vertical(vertical), .ship_lens(ship_lens), .port(place_port),
		.done(place_done), .ok(place_ok), .fleet_done(fleet_done),
		.cells_placed(cells_placed), .active(placer_active)
	);

	shot_resolver resolver_inst (
		.clk_in(clk_in), .rst_n(rst_n), .start(fire_start), .col(cur_col), .row(cur_row),
		.port(shot_port), .done(shot_done), .result(shot_result), .hits(hits),
		.active(resolver_active)
	);

	grid_arbiter arbiter_inst (
		.clk_in(clk_in), .rst_n(rst_n), .place_port(place_port), .shot_port(shot_port),
		.store_port(store_port), .place_req(place_req), .rotate_req(rotate_req),
		.fire_req(fire_req), .fleet_done(fleet_done), .cells_placed(cells_placed),
		.hits(hits), .placer_active(placer_active), .resolver_active(resolver_active),
		.clearing(clearing), .place_start(place_start), .fire_start(fire_start),
		.vertical(vertical), .phase(phase), .busy(busy)
	);

endmodule

// File: design/grid_arbiter.sv
module grid_arbiter (
	input  logic clk_in,
	input  logic rst_n,
	cell_port_if.store place_port,
	cell_port_if.store shot_port,
	cell_port_if.requester store_port,
	input  logic place_req,
	input  logic rotate_req,
	input  logic fire_req,
	input  logic fleet_done,
	input  logic [7:0] cells_placed,
	input  logic [7:0] hits,
	input  logic placer_active,
	input  logic resolver_active,
	input  logic clearing,
	output logic place_start,
	output logic fire_start,
	output logic vertical,
	output logic [game_pkg::PHASE_W-1:0] phase,
	output logic busy
);

	logic sel_place;

	// any running operation blocks new strobes
	assign busy = clearing | placer_active | resolver_active;

	// strobes become starts only in their own phase
	assign place_start = place_req && (phase == game_pkg::PH_PLACE) && !busy && !fleet_done;
	assign fire_start  = fire_req && (phase == game_pkg::PH_FIRE) && !busy;

	////////////////////////////////////////
	// access port mux by phase
	////////////////////////////////////////
	assign sel_place = (phase == game_pkg::PH_PLACE);

	assign store_port.col   = sel_place ? place_port.col : shot_port.col;
	assign store_port.row   = sel_place ? place_port.row : shot_port.row;
	assign store_port.wdata = sel_place ? place_port.wdata : shot_port.wdata;
	assign store_port.we    = sel_place ? place_port.we : shot_port.we;
	// read data fans out to both sides
	assign place_port.rdata = store_port.rdata;
	assign shot_port.rdata  = store_port.rdata;

	////////////////////////////////////////
	// phase and ship direction
	////////////////////////////////////////
	always_ff @(posedge clk_in)
	begin
		if (!rst_n)
		begin
			phase    <= game_pkg::PH_PLACE;
			vertical <= 1'b0;
		end
		else
		begin
			case (phase)
				game_pkg::PH_PLACE:
				begin
					// last ship placed, firing starts next cycle
					if (fleet_done)
						phase <= game_pkg::PH_FIRE;
					if (rotate_req && !busy)
						vertical <= !vertical;
				end
				game_pkg::PH_FIRE:
				begin
					// every ship cell hit
					if (cells_placed != '0 && hits == cells_placed)
						phase <= game_pkg::PH_OVER;
				end
				default:
					phase <= game_pkg::PH_OVER;
			endcase
		end
	end

endmodule

// File: design/shot_resolver.sv
module shot_resolver (
	input  logic clk_in,
	input  logic rst_n,
	input  logic start,
	input  logic [grid_geom_pkg::CELL_IDX_W-1:0] col,
	input  logic [grid_geom_pkg::CELL_IDX_W-1:0] row,
	cell_port_if.requester port,
	output logic done,
	output logic [game_pkg::RES_W-1:0] result,
	output logic [7:0] hits,
	output logic active
);

	// sequencer states
	localparam logic [1:0] S_IDLE   = 2'd0;
	localparam logic [1:0] S_READ   = 2'd1;
	localparam logic [1:0] S_DECIDE = 2'd2;

	logic [1:0] state;
	logic [grid_geom_pkg::CELL_IDX_W-1:0] tgt_col;
	logic [grid_geom_pkg::CELL_IDX_W-1:0] tgt_row;
	logic repeat_shot;
	logic ship_cell;

	// decode the word read back in the decide cycle
	assign repeat_shot = port.rdata[game_pkg::SHOT_LSB +: game_pkg::FIELD_W] != game_pkg::SHOT_NONE;
	assign ship_cell = port.rdata[game_pkg::LAYOUT_LSB +: game_pkg::FIELD_W] == game_pkg::LAY_SHIP;

	assign port.col = tgt_col;
	assign port.row = tgt_row;
	// mark only a fresh shot
	assign port.we  = (state == S_DECIDE) && !repeat_shot;
	assign active   = (state != S_IDLE);

	// keep the placement field, set the shot field
	always_comb
	begin
		port.wdata = port.rdata;
		port.wdata[game_pkg::SHOT_LSB +: game_pkg::FIELD_W] = game_pkg::SHOT_FIRED;
	end

	always_ff @(posedge clk_in)
	begin
		if (!rst_n)
		begin
			state  <= S_IDLE;
			done   <= 1'b0;
			result <= game_pkg::RES_MISS;
			hits   <= '0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				S_IDLE:
				begin
					// cycle 0, latch the target
					if (start)
					begin
						tgt_col <= col;
						tgt_row <= row;
						state   <= S_READ;
					end
				end
				S_READ:
					state <= S_DECIDE;
				default:
				begin
					// cycle 2, write and classify, done shows in cycle 3
					state <= S_IDLE;
					done  <= 1'b1;
					if (repeat_shot)
						result <= game_pkg::RES_REPEAT;
					else if (ship_cell)
					begin
						result <= game_pkg::RES_HIT;
						hits   <= hits + 1'b1;
					end
					else
						result <= game_pkg::RES_MISS;
				end
			endcase
		end
	end

endmodule

// File: design/fleet_placer.sv
module fleet_placer #(
	parameter int GRID_COLS = grid_geom_pkg::DEF_GRID_COLS,
	parameter int GRID_ROWS = grid_geom_pkg::DEF_GRID_ROWS,
	parameter int NUM_SHIPS = grid_geom_pkg::DEF_NUM_SHIPS
) (
	input  logic clk_in,
	input  logic rst_n,
	input  logic start,
	input  logic [grid_geom_pkg::CELL_IDX_W-1:0] col,
	input  logic [grid_geom_pkg::CELL_IDX_W-1:0] row,
	input  logic vertical,
	input  logic [NUM_SHIPS*grid_geom_pkg::SHIP_LEN_W-1:0] ship_lens,
	cell_port_if.requester port,
	output logic done,
	output logic ok,
	output logic fleet_done,
	output logic [7:0] cells_placed,
	output logic active
);

	localparam int LEN_W = grid_geom_pkg::SHIP_LEN_W;
	localparam int PTR_W = $clog2(NUM_SHIPS + 1);
	// sequencer states
	localparam logic [1:0] S_IDLE  = 2'd0;
	localparam logic [1:0] S_READ  = 2'd1;
	localparam logic [1:0] S_LAST  = 2'd2;
	localparam logic [1:0] S_WRITE = 2'd3;
	localparam logic [game_pkg::CELL_W-1:0] SHIP_WORD =
		game_pkg::LAY_SHIP << game_pkg::LAYOUT_LSB;

	logic [1:0] state;
	logic [PTR_W-1:0] ptr;
	logic [LEN_W-1:0] cur_len;
	logic [LEN_W-1:0] len;
	logic [LEN_W-1:0] step;
	logic [grid_geom_pkg::CELL_IDX_W-1:0] base_col;
	logic [grid_geom_pkg::CELL_IDX_W-1:0] base_row;
	logic vert;
	logic [LEN_W:0] end_pos;
	logic fits;
	logic conflict;

	// length of the ship being placed
	assign cur_len = ship_lens[ptr*LEN_W +: LEN_W];

	// last footprint cell must stay inside the grid
	assign end_pos = (vertical ? {1'b0, row} : {1'b0, col}) + {1'b0, cur_len} - 1'b1;
	assign fits = (cur_len != '0) && (int'(end_pos) < (vertical ? GRID_ROWS : GRID_COLS));

	// previous read found something other than water
	assign conflict = port.rdata[game_pkg::LAYOUT_LSB +: game_pkg::FIELD_W] != game_pkg::LAY_WATER;

	// footprint walk along the chosen direction
	assign port.col   = vert ? base_col : base_col + step;
	assign port.row   = vert ? base_row + step : base_row;
	assign port.we    = (state == S_WRITE);
	assign port.wdata = SHIP_WORD;
	assign active     = (state != S_IDLE);

	always_ff @(posedge clk_in)
	begin
		if (!rst_n)
		begin
			state        <= S_IDLE;
			ptr          <= '0;
			step         <= '0;
			vert         <= 1'b0;
			done         <= 1'b0;
			ok           <= 1'b0;
			fleet_done   <= 1'b0;
			cells_placed <= '0;
		end
		else
		begin
			done <= 1'b0;
			ok   <= 1'b0;
			case (state)
				S_IDLE:
				begin
					if (start)
					begin
						base_col <= col;
						base_row <= row;
						vert     <= vertical;
						len      <= cur_len;
						step     <= '0;
						// out of bounds is rejected at once
						if (fits)
							state <= S_READ;
						else
							done <= 1'b1;
					end
				end
				S_READ:
				begin
					// rdata belongs to cell step-1
					if (step != '0 && conflict)
					begin
						state <= S_IDLE;
						done  <= 1'b1;
					end
					else if (step == len - 1'b1)
						state <= S_LAST;
					else
						step <= step + 1'b1;
				end
				S_LAST:
				begin
					// check of the final footprint cell
					if (conflict)
					begin
						state <= S_IDLE;
						done  <= 1'b1;
					end
					else
					begin
						step  <= '0;
						state <= S_WRITE;
					end
				end
				default:
				begin
					if (step == len - 1'b1)
					begin
						state        <= S_IDLE;
						done         <= 1'b1;
						ok           <= 1'b1;
						ptr          <= ptr + 1'b1;
						cells_placed <= cells_placed + 8'(len);
						fleet_done   <= (ptr == PTR_W'(NUM_SHIPS - 1));
					end
					else
						step <= step + 1'b1;
				end
			endcase
		end
	end

endmodule

// File: design/cell_store.sv
module cell_store #(
	parameter int GRID_COLS = grid_geom_pkg::DEF_GRID_COLS,
	parameter int GRID_ROWS = grid_geom_pkg::DEF_GRID_ROWS
) (
	input  logic clk_in,
	input  logic rst_n,
	cell_port_if.store port,
	input  logic [grid_geom_pkg::CELL_IDX_W-1:0] scan_col,
	input  logic [grid_geom_pkg::CELL_IDX_W-1:0] scan_row,
	input  logic scan_in_grid,
	output logic [game_pkg::CELL_W-1:0] scan_cell,
	output logic scan_valid,
	output logic clearing
);

	// one cell word per grid position
	logic [game_pkg::CELL_W-1:0] mem [GRID_ROWS][GRID_COLS];
	logic [grid_geom_pkg::CELL_IDX_W-1:0] clr_row;
	logic port_hit;

	// access outside the grid reads zero and writes nothing
	assign port_hit = (int'(port.col) < GRID_COLS) && (int'(port.row) < GRID_ROWS);

	////////////////////////////////////////
	// clear sweep after reset
	////////////////////////////////////////
	always_ff @(posedge clk_in)
	begin
		if (!rst_n)
		begin
			clearing   <= 1'b1;
			clr_row    <= '0;
			scan_valid <= 1'b0;
		end
		else
		begin
			scan_valid <= scan_in_grid;
			if (clearing)
			begin
				// one row per cycle
				if (clr_row == grid_geom_pkg::CELL_IDX_W'(GRID_ROWS - 1))
					clearing <= 1'b0;
				clr_row <= clr_row + 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// array write and both reads
	////////////////////////////////////////
	always_ff @(posedge clk_in)
	begin
		// sweep owns the array while it runs
		if (clearing)
		begin
			for (int c = 0; c < GRID_COLS; c++)
				mem[clr_row][c] <= '0;
		end
		else if (port.we && port_hit)
			mem[port.row][port.col] <= port.wdata;
		port.rdata <= port_hit ? mem[port.row][port.col] : '0;
		// scan word for the display side
		scan_cell <= scan_in_grid ? mem[scan_row][scan_col] : '0;
	end

endmodule

// File: design/pos_to_cell.sv
module pos_to_cell #(
	parameter int GRID_X0   = grid_geom_pkg::DEF_GRID_X0,
	parameter int GRID_Y0   = grid_geom_pkg::DEF_GRID_Y0,
	parameter int CELL_W_PX = grid_geom_pkg::DEF_CELL_W,
	parameter int CELL_H_PX = grid_geom_pkg::DEF_CELL_H,
	parameter int GRID_COLS = grid_geom_pkg::DEF_GRID_COLS,
	parameter int GRID_ROWS = grid_geom_pkg::DEF_GRID_ROWS
) (
	input  logic clk_in,
	input  logic rst_n,
	input  logic [grid_geom_pkg::COORD_W-1:0] pos_x,
	input  logic [grid_geom_pkg::COORD_W-1:0] pos_y,
	output logic [grid_geom_pkg::CELL_IDX_W-1:0] cell_col,
	output logic [grid_geom_pkg::CELL_IDX_W-1:0] cell_row,
	output logic in_grid
);

	localparam int IDX_W = grid_geom_pkg::CELL_IDX_W;

	// find the bracket holding pos, msb set when inside the grid
	function automatic logic [IDX_W:0] bracket(
		input logic [grid_geom_pkg::COORD_W-1:0] pos,
		input int origin,
		input int size,
		input int count
	);
		logic in_range;
		logic [IDX_W-1:0] idx;
		idx = '0;
		// last boundary point at or below pos wins
		for (int i = 1; i < (1 << IDX_W); i++)
		begin
			if (i < count && int'(pos) >= origin + i * size)
				idx = IDX_W'(i);
		end
		in_range = (int'(pos) >= origin) && (int'(pos) < origin + count * size);
		return {in_range, idx};
	endfunction

	logic [IDX_W:0] x_br;
	logic [IDX_W:0] y_br;

	assign x_br = bracket(pos_x, GRID_X0, CELL_W_PX, GRID_COLS);
	assign y_br = bracket(pos_y, GRID_Y0, CELL_H_PX, GRID_ROWS);

	// in-grid flag, cleared by reset
	always_ff @(posedge clk_in)
	begin
		if (!rst_n)
			in_grid <= 1'b0;
		else
			in_grid <= x_br[IDX_W] & y_br[IDX_W];
	end

	// cell index registered alongside the flag
	always_ff @(posedge clk_in)
	begin
		cell_col <= x_br[IDX_W-1:0];
		cell_row <= y_br[IDX_W-1:0];
	end

endmodule

// File: design/cell_port_if.sv
interface cell_port_if;

	// cell index of the access
	logic [grid_geom_pkg::CELL_IDX_W-1:0] col;
	logic [grid_geom_pkg::CELL_IDX_W-1:0] row;
	// write side, takes effect at the clock edge
	logic [game_pkg::CELL_W-1:0] wdata;
	logic we;
	// read side, one cycle after col and row
	logic [game_pkg::CELL_W-1:0] rdata;

	// sequencer side
	modport requester (
		output col, row, wdata, we,
		input  rdata
	);

	// memory side
	modport store (
		input  col, row, wdata, we,
		output rdata
	);

endinterface

// File: design/game_pkg.sv
package game_pkg;

	////////////////////////////////////////
	// game phases
	////////////////////////////////////////
	localparam int PHASE_W = 2;
	localparam logic [PHASE_W-1:0] PH_PLACE = 2'd0;
	localparam logic [PHASE_W-1:0] PH_FIRE  = 2'd1;
	localparam logic [PHASE_W-1:0] PH_OVER  = 2'd2;

	////////////////////////////////////////
	// cell word layout
	////////////////////////////////////////
	// bit 4 spare, bits 3:2 shot field, bits 1:0 placement field
	localparam int CELL_W     = 5;
	localparam int FIELD_W    = 2;
	localparam int LAYOUT_LSB = 0;
	localparam int SHOT_LSB   = 2;

	// placement field codes
	localparam logic [FIELD_W-1:0] LAY_WATER = 2'b00;
	localparam logic [FIELD_W-1:0] LAY_SHIP  = 2'b01;
	// shot field codes
	localparam logic [FIELD_W-1:0] SHOT_NONE  = 2'b00;
	localparam logic [FIELD_W-1:0] SHOT_FIRED = 2'b01;

	// shot outcome reported with shot_done
	localparam int RES_W = 2;
	localparam logic [RES_W-1:0] RES_MISS   = 2'd0;
	localparam logic [RES_W-1:0] RES_HIT    = 2'd1;
	localparam logic [RES_W-1:0] RES_REPEAT = 2'd2;

endpackage

// File: design/grid_geom_pkg.sv
package grid_geom_pkg;

	// pixel coordinate width of the display
	localparam int COORD_W    = 10;
	// row or column index, grids up to 16 by 16
	localparam int CELL_IDX_W = 4;
	// one ship length
	localparam int SHIP_LEN_W = 4;

	////////////////////////////////////////
	// default geometry for the top level
	////////////////////////////////////////
	localparam int DEF_GRID_X0    = 48;
	localparam int DEF_GRID_Y0    = 64;
	localparam int DEF_CELL_W     = 32;
	localparam int DEF_CELL_H     = 32;
	localparam int DEF_GRID_COLS  = 10;
	localparam int DEF_GRID_ROWS  = 10;
	localparam int DEF_NUM_SHIPS  = 5;

endpackage
